// File: src.f
rtl/pkt_pkg.sv
rtl/it_fifo.sv
rtl/pkt_parser_fsm.sv
rtl/payload_counter.sv
rtl/pkt_forward.sv
rtl/pkt_filter_top.sv
dv/pkt_filter_props.sv
dv/pkt_filter_tb.sv

// File: dv/pkt_filter_tb.sv
/*
  Testbench for the packet filter.
  Clock and reset, LCG-driven packet generator,
  input driver with gaps, output monitor with stalls,
  expected-word queue and header counts as the model,
  five directed-random tests and the final summary.
*/
`default_nettype none

module pkt_filter_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEED    = 51;
  localparam int TIMEOUT = 20000;  // Cycles per wait loop

  logic        clk;
  logic        reset;
  logic        irdy_in;
  logic        trdy_in;
  logic [7:0]  data_in;
  logic        irdy_out;
  logic        trdy_out;
  logic [7:0]  data_out;
  logic        eop_out;
  logic [15:0] pkt_count;
  logic [15:0] drop_count;

  logic [31:0] lcg_state = SEED;
  logic [7:0]  in_q[$];   // Bytes still to send
  logic [8:0]  exp_q[$];  // {eop, byte} expected at the output
  logic [15:0] exp_pkt  = '0;
  logic [15:0] exp_drop = '0;
  logic        stream_en = 1'b0;
  logic        hold_out  = 1'b0;
  logic        in_accept = 1'b0;
  int          gap_pct   = 0;
  int          stall_pct = 0;
  int          low_in_cycles = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  pkt_filter_top u_pkt_filter_top (
    .clk        (clk),
    .reset      (reset),
    .irdy_in    (irdy_in),
    .trdy_in    (trdy_in),
    .data_in    (data_in),
    .irdy_out   (irdy_out),
    .trdy_out   (trdy_out),
    .data_out   (data_out),
    .eop_out    (eop_out),
    .pkt_count  (pkt_count),
    .drop_count (drop_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (lcg_next() >> 8) % n;  // Low bits of an LCG are weak
  endfunction

  // Testbench errors plus failures of the bound assertions
  function automatic int total_errors();
    return error_count + u_pkt_filter_top.u_props.fail_count;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns: %s mismatch, got %0h, expected %0h",
               $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #3;  // Away from driver and monitor times
  endtask

  // Header then payload, model updated from the header rules
  task automatic add_packet(input logic drop, input logic [6:0] len);
    logic [7:0] b;
    in_q.push_back({drop, len});
    if (drop)
      exp_drop++;
    else
      exp_pkt++;
    for (int i = 0; i < len; i++)
    begin
      b = 8'(rand_below(256));
      in_q.push_back(b);
      if (!drop)
        exp_q.push_back({(i == len - 1), b});
    end
  endtask

  task automatic wait_drain(input string what);
    int cycles;
    cycles = 0;
    while (!(in_q.size() == 0 && exp_q.size() == 0 && pkt_count == exp_pkt &&
             drop_count == exp_drop) && cycles < TIMEOUT)
    begin
      step();
      cycles++;
    end
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout: %s did not drain within %0d cycles", what, TIMEOUT);
      error_count++;
    end
    check_value(pkt_count, exp_pkt, "kept header count");
    check_value(drop_count, exp_drop, "dropped header count");
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() != errs_before)
    begin
      tests_failed++;
      $display("Test %s: FAILED", name);
    end
    else
      $display("Test %s: ok", name);
  endtask

  // --------------------
  // Driver and monitor
  // --------------------
  initial
  begin : stream_driver
    forever
    begin
      @(posedge clk);
      #1;
      if (in_accept)
        void'(in_q.pop_front());
      if (!stream_en)
      begin
        irdy_in  = 1'b0;
        trdy_out = 1'b1;
      end
      else
      begin
        // A byte once offered stays until taken
        if (!(irdy_in && !in_accept))
        begin
          irdy_in = (in_q.size() != 0) && (rand_below(100) >= gap_pct);
          if (irdy_in)
            data_in = in_q[0];
        end
        trdy_out = hold_out ? 1'b0 : (rand_below(100) >= stall_pct);
      end
    end
  end

  initial
  begin : output_monitor
    forever
    begin
      @(negedge clk);
      in_accept = irdy_in && trdy_in;
      if (stream_en && !trdy_in)
        low_in_cycles++;
      if (irdy_out && trdy_out)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Output byte %0h appeared with no byte expected at %0t ns", data_out, $time);
          error_count++;
        end
        else
          check_value({eop_out, data_out}, exp_q.pop_front(), "output word");
      end
    end
  end

  // --------------------
  // Tests
  // --------------------
  initial
  begin : main
    int errs;
    reset    = 1'b1;
    irdy_in  = 1'b0;
    data_in  = '0;
    trdy_out = 1'b1;

    // Test 1, reset state
    errs = total_errors();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    step();
    check_value(irdy_out, 1'b0, "irdy_out after reset");
    check_value(trdy_in, 1'b1, "trdy_in after reset");
    check_value(pkt_count, 16'd0, "pkt_count after reset");
    check_value(drop_count, 16'd0, "drop_count after reset");
    end_test("reset_state", errs);
    stream_en = 1'b1;

    // Test 2, kept packets, free-running output
    errs = total_errors();
    gap_pct = 20;
    for (int i = 0; i < 6; i++)
      add_packet(1'b0, 7'(1 + rand_below(127)));
    wait_drain("kept packets");
    end_test("kept_packets", errs);

    // Test 3, drops and empty packets mixed in
    errs = total_errors();
    for (int i = 0; i < 12; i++)
      add_packet(1'(rand_below(2)), (i % 3 == 0) ? 7'd0 : 7'(rand_below(128)));
    wait_drain("mixed packets");
    end_test("drop_and_empty", errs);

    // Test 4, random output stalls
    errs = total_errors();
    gap_pct = 5;
    stall_pct = 70;
    low_in_cycles = 0;
    for (int i = 0; i < 10; i++)
      add_packet(rand_below(4) == 0, 7'(1 + rand_below(127)));
    wait_drain("stalled stream");
    check_value(low_in_cycles != 0, 1'b1, "input back-pressure seen");
    end_test("output_stalls", errs);

    // Test 5, drops queued behind a stalled kept packet
    errs = total_errors();
    hold_out = 1'b1;
    gap_pct = 0;
    add_packet(1'b1, 7'd60);
    add_packet(1'b0, 7'd100);
    repeat (3) add_packet(1'b1, 7'd127);
    for (int c = 0; trdy_in; c++)
    begin
      if (c >= TIMEOUT)
      begin
        $display("Timeout: input FIFO never filled while output was held");
        error_count++;
        break;
      end
      step();
    end
    // Only the leading drop has been counted so far
    check_value(drop_count, exp_drop - 16'd3, "drop count during stall");
    check_value(pkt_count, exp_pkt, "kept count during stall");
    hold_out = 1'b0;
    stall_pct = 0;
    wait_drain("drops behind stall");
    end_test("stall_with_drops", errs);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/pkt_filter_props.sv
/*
  Concurrent assertions for the packet filter top level:
  output idle after reset, pops only on a valid byte,
  no push into a full output FIFO, no count-down past zero,
  and a running count of assertion failures.
  Bound into every pkt_filter_top instance.
*/
`default_nettype none

module pkt_filter_props (
  input wire logic clk,
  input wire logic reset,
  input wire logic irdy_out,
  input wire logic pop,
  input wire logic byte_irdy,
  input wire logic push,
  input wire logic out_space,
  input wire logic cnt_dec,
  input wire logic zero
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Assertion failures so far

  // --------------------
  // Reset behavior
  // --------------------
  a_idle_after_reset: assert property (@(posedge clk) reset |=> !irdy_out)
    else
    begin
      $error("output irdy high right after reset");
      fail_count++;
    end

  // --------------------
  // Datapath handshakes
  // --------------------
  a_pop_needs_byte: assert property (@(posedge clk) disable iff (reset) pop |-> byte_irdy)
    else
    begin
      $error("input FIFO popped with no byte present");
      fail_count++;
    end

  a_push_needs_space: assert property (@(posedge clk) disable iff (reset) push |-> out_space)
    else
    begin
      $error("push into a full output FIFO");
      fail_count++;
    end

  // Counter must never be asked to go below zero
  a_dec_not_zero: assert property (@(posedge clk) disable iff (reset) cnt_dec |-> !zero)
    else
    begin
      $error("payload counter decremented at zero");
      fail_count++;
    end

endmodule

bind pkt_filter_top pkt_filter_props u_props (
  .clk       (clk),
  .reset     (reset),
  .irdy_out  (irdy_out),
  .pop       (pop),
  .byte_irdy (byte_irdy),
  .push      (push),
  .out_space (out_space),
  .cnt_dec   (cnt_dec),
  .zero      (zero)
);

`default_nettype wire

// File: rtl/pkt_filter_top.sv
/*
  Packet filter top level.
  Input FIFO, parser FSM, payload counter, forwarder
  and output FIFO, with the output word split into
  eop flag and data byte.
*/
`default_nettype none

module pkt_filter_top (
  input  wire logic                       clk,
  input  wire logic                       reset,
  // Input byte stream
  input  wire logic                       irdy_in,
  output logic                            trdy_in,
  input  wire logic [pkt_pkg::DATA_W-1:0] data_in,
  // Output payload stream
  output logic                            irdy_out,
  input  wire logic                       trdy_out,
  output logic [pkt_pkg::DATA_W-1:0]      data_out,
  output logic                            eop_out,
  // Statistics
  output logic [pkt_pkg::CNT_W-1:0]       pkt_count,
  output logic [pkt_pkg::CNT_W-1:0]       drop_count
);

  // --------------------
  // Internal nets
  // --------------------
  logic                       byte_irdy;
  logic [pkt_pkg::DATA_W-1:0] byte_data;
  logic                       pop;
  logic                       hdr_take;
  logic                       fwd_take;
  logic                       cnt_load;
  logic                       cnt_dec;
  logic                       last;
  logic                       zero;
  logic                       out_space;  // Output FIFO not full
  logic                       push;
  logic [pkt_pkg::OUT_W-1:0]  push_word;
  logic [pkt_pkg::OUT_W-1:0]  out_word;

  it_fifo #(
    .width (pkt_pkg::DATA_W),
    .depth (pkt_pkg::FIFO_DEPTH),
    .asz   (pkt_pkg::FIFO_ASZ),
    .npt   (1'b0)
  ) u_in_fifo (
    .clk      (clk),
    .reset    (reset),
    .irdy_in  (irdy_in),
    .trdy_in  (trdy_in),
    .data_in  (data_in),
    .irdy_out (byte_irdy),
    .trdy_out (pop),
    .data_out (byte_data)
  );

  pkt_parser_fsm u_parser (
    .clk       (clk),
    .reset     (reset),
    .byte_irdy (byte_irdy),
    .byte_data (byte_data),
    .out_space (out_space),
    .last      (last),
    .zero      (zero),
    .pop       (pop),
    .hdr_take  (hdr_take),
    .fwd_take  (fwd_take),
    .cnt_load  (cnt_load),
    .cnt_dec   (cnt_dec)
  );

  payload_counter u_counter (
    .clk    (clk),
    .reset  (reset),
    .load   (cnt_load),
    .dec    (cnt_dec),
    .len_in (byte_data[pkt_pkg::LEN_W-1:0]),  // Length field of the header
    .last   (last),
    .zero   (zero)
  );

  pkt_forward u_forward (
    .clk        (clk),
    .reset      (reset),
    .hdr_take   (hdr_take),
    .fwd_take   (fwd_take),
    .byte_data  (byte_data),
    .last       (last),
    .push       (push),
    .push_word  (push_word),
    .pkt_count  (pkt_count),
    .drop_count (drop_count)
  );

  it_fifo #(
    .width (pkt_pkg::OUT_W),
    .depth (pkt_pkg::FIFO_DEPTH),
    .asz   (pkt_pkg::FIFO_ASZ),
    .npt   (1'b0)
  ) u_out_fifo (
    .clk      (clk),
    .reset    (reset),
    .irdy_in  (push),
    .trdy_in  (out_space),
    .data_in  (push_word),
    .irdy_out (irdy_out),
    .trdy_out (trdy_out),
    .data_out (out_word)
  );

  assign eop_out  = out_word[pkt_pkg::OUT_W-1];
  assign data_out = out_word[pkt_pkg::DATA_W-1:0];

endmodule

`default_nettype wire

// File: rtl/pkt_forward.sv
/*
  Forwarding datapath.
  Builds the output word with its end-of-packet flag,
  pushes it to the output FIFO, and keeps the
  kept and dropped header counters.
*/
`default_nettype none

module pkt_forward (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       hdr_take,
  input  wire logic                       fwd_take,
  input  wire logic [pkt_pkg::DATA_W-1:0] byte_data,
  input  wire logic                       last,
  output logic                            push,
  output logic [pkt_pkg::OUT_W-1:0]       push_word,
  output logic [pkt_pkg::CNT_W-1:0]       pkt_count,
  output logic [pkt_pkg::CNT_W-1:0]       drop_count
);

  pkt_pkg::pkt_hdr_u hdr;

  assign hdr = byte_data;

  // --------------------
  // Output word
  // --------------------
  assign push      = fwd_take;
  assign push_word = {last, byte_data};  // eop in the top bit

  // --------------------
  // Header statistics
  // --------------------
  // Both counters wrap at 2^16
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pkt_count  <= '0;
      drop_count <= '0;
    end
    else if (hdr_take)
    begin
      if (hdr.fld.drop)
        drop_count <= drop_count + 1'b1;
      else
        pkt_count <= pkt_count + 1'b1;  // Zero-length kept headers count too
    end
  end

endmodule

`default_nettype wire

// File: rtl/payload_counter.sv
/*
  Payload byte counter.
  Loaded with the header length, counts down per
  payload byte, flags the last and the empty count.
*/
`default_nettype none

module payload_counter (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      load,
  input  wire logic                      dec,
  input  wire logic [pkt_pkg::LEN_W-1:0] len_in,
  output logic                           last,
  output logic                           zero
);

  logic [pkt_pkg::LEN_W-1:0] remain;  // Bytes still to come

  always_ff @(posedge clk)
  begin
    if (reset)
      remain <= '0;
    else if (load)
      remain <= len_in;
    else if (dec && (remain != '0))
      remain <= remain - 1'b1;
  end

  assign last = (remain == pkt_pkg::LEN_W'(1));
  assign zero = (remain == '0);

endmodule

`default_nettype wire

// File: rtl/pkt_parser_fsm.sv
/*
  Packet parser FSM.
  Reads header bytes, steers payload pops to forward
  or discard, and strobes the payload counter.
*/
`default_nettype none

module pkt_parser_fsm (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      byte_irdy,
  input  wire logic [pkt_pkg::DATA_W-1:0] byte_data,
  input  wire logic                      out_space,
  input  wire logic                      last,
  input  wire logic                      zero,
  output logic                           pop,
  output logic                           hdr_take,
  output logic                           fwd_take,
  output logic                           cnt_load,
  output logic                           cnt_dec
);

  pkt_pkg::parser_state_e state;
  pkt_pkg::parser_state_e nxt_state;
  pkt_pkg::pkt_hdr_u      hdr;

  assign hdr = byte_data;  // Only meaningful in ST_HEADER

  // --------------------
  // Pop and next state
  // --------------------
  always_comb
  begin
    nxt_state = state;
    pop       = 1'b0;
    hdr_take  = 1'b0;
    fwd_take  = 1'b0;
    cnt_load  = 1'b0;
    cnt_dec   = 1'b0;

    case (state)
      pkt_pkg::ST_HEADER:
      begin
        pop      = byte_irdy;
        hdr_take = byte_irdy;
        cnt_load = byte_irdy;
        if (byte_irdy)
        begin
          if (hdr.fld.len == '0)
            nxt_state = pkt_pkg::ST_HEADER;  // Empty packet, nothing to do
          else if (hdr.fld.drop)
            nxt_state = pkt_pkg::ST_SKIP;
          else
            nxt_state = pkt_pkg::ST_FWD;
        end
      end

      pkt_pkg::ST_FWD:
      begin
        pop      = byte_irdy && out_space;  // Waits on output space
        fwd_take = pop;
        cnt_dec  = pop;
        if (zero || (pop && last))
          nxt_state = pkt_pkg::ST_HEADER;
      end

      pkt_pkg::ST_SKIP:
      begin
        pop     = byte_irdy;  // Drains regardless of output
        cnt_dec = pop;
        if (zero || (pop && last))
          nxt_state = pkt_pkg::ST_HEADER;
      end

      default:
        nxt_state = pkt_pkg::ST_HEADER;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= pkt_pkg::ST_HEADER;
    else
      state <= nxt_state;
  end

endmodule

`default_nettype wire

// File: rtl/it_fifo.sv
/*
  Generic irdy/trdy FIFO.
  Circular buffer with wrap-bit pointers, optional
  non-power-of-two depth, registered head word.
*/
`default_nettype none

module it_fifo #(
  parameter int width = 8,
  parameter int depth = 16,
  parameter int asz   = 4,
  parameter bit npt   = 1'b0  // Depth is not a power of two
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             irdy_in,
  output logic                  trdy_in,
  input  wire logic [width-1:0] data_in,
  output logic                  irdy_out,
  input  wire logic             trdy_out,
  output logic [width-1:0]      data_out
);

  logic [width-1:0] mem [0:depth-1];

  logic [asz:0] wrptr;
  logic [asz:0] rdptr;
  logic [asz:0] nxt_wrptr;
  logic [asz:0] nxt_rdptr;
  logic [asz:0] wrptr_p1;
  logic [asz:0] rdptr_p1;
  logic         full;
  logic         wr_en;
  logic         rd_en;
  logic         nxt_irdy;

  assign trdy_in = !full;
  assign wr_en   = irdy_in && !full;
  assign rd_en   = trdy_out && irdy_out;  // Head word taken this cycle

  // --------------------
  // Pointer arithmetic
  // --------------------
  always_comb
  begin
    wrptr_p1 = wrptr + 1'b1;
    rdptr_p1 = rdptr + 1'b1;

    // Odd depth wraps the low bits early and flips the wrap bit by hand
    if (npt)
    begin
      if (wrptr_p1[asz-1:0] == depth)
      begin
        wrptr_p1[asz-1:0] = '0;
        wrptr_p1[asz]     = ~wrptr[asz];
      end
      if (rdptr_p1[asz-1:0] == depth)
      begin
        rdptr_p1[asz-1:0] = '0;
        rdptr_p1[asz]     = ~rdptr[asz];
      end
    end

    // Same slot, opposite lap
    full = (wrptr[asz-1:0] == rdptr[asz-1:0]) && (wrptr[asz] != rdptr[asz]);

    nxt_wrptr = wr_en ? wrptr_p1 : wrptr;
    nxt_rdptr = rd_en ? rdptr_p1 : rdptr;

    // Something left after this cycle's read
    nxt_irdy = (wrptr != nxt_rdptr);
  end

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr    <= '0;
      rdptr    <= '0;
      irdy_out <= 1'b0;
    end
    else
    begin
      wrptr    <= nxt_wrptr;
      rdptr    <= nxt_rdptr;
      irdy_out <= nxt_irdy;
    end
  end

  // Storage and the registered head word
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wrptr[asz-1:0]] <= data_in;
    data_out <= mem[nxt_rdptr[asz-1:0]];  // Prefetch next head
  end

endmodule

`default_nettype wire

// File: rtl/pkt_pkg.sv
/*
  Shared definitions for the packet filter:
  byte, length, output word and statistics widths,
  FIFO sizing for both FIFO instances,
  header byte union (raw byte or drop flag plus length),
  parser state encoding
*/
`default_nettype none

package pkt_pkg;

  // --------------------
  // Widths and sizes
  // --------------------
  localparam int DATA_W     = 8;
  localparam int LEN_W      = 7;
  localparam int OUT_W      = DATA_W + 1;  // eop flag on top of the byte
  localparam int CNT_W      = 16;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_ASZ   = 4;

  // Header byte, read either whole or as drop flag plus payload length
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic             drop;  // Bit 7
      logic [LEN_W-1:0] len;   // Payload bytes, 0 to 127
    } fld;
  } pkt_hdr_u;

  // --------------------
  // Parser states
  // --------------------
  typedef enum logic [1:0] {
    ST_HEADER,  // Waiting for a header byte
    ST_FWD,     // Passing payload to the output FIFO
    ST_SKIP     // Draining payload of a dropped packet
  } parser_state_e;

endpackage

`default_nettype wire
